//--- Bender.yml
package:
  name: glay_cache_subsystem

sources:
  - include_dirs:
      - source
    files:
      - source/pkg_memory.sv
      - source/pkg_cache.sv
      - source/cache_response_fifo.sv
      - source/cache_request_decode.sv
      - source/cache_line_store.sv
      - source/cache_generator_response.sv
      - source/cache_subsystem_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_cache_subsystem.sv

//--- list.f
+incdir+source
source/pkg_memory.sv
source/pkg_cache.sv
source/cache_response_fifo.sv
source/cache_request_decode.sv
source/cache_line_store.sv
source/cache_generator_response.sv
source/cache_subsystem_top.sv
sim/tb_clock_gen.sv
sim/tb_cache_subsystem.sv

//--- sim/tb_cache_subsystem.sv
/*
  Cache subsystem testbench
  Random reads and writes into the cache subsystem, a shadow line
  array and per-requestor expected queues as reference model, checks
  of every returned packet, of the reset sequence and the FIFO flags
*/

`timescale 1ns/1ps
`include "glay_cache_config.svh"

module tb_cache_subsystem;

  import pkg_memory::*;
  import pkg_cache::*;

  localparam int N              = `NUM_MEMORY_REQUESTOR;
  localparam int SEED           = 70045;
  localparam int MAX_IN_FLIGHT  = `CACHE_FIFO_PROG_THRESH - 1;
  localparam int MAX_BURST      = 12;
  localparam int SETTLE_CYCLES  = 8;
  localparam int WR_PAIRS       = 24;
  localparam int READS          = 48;
  localparam int MIXED          = 48;
  localparam int BURSTS         = 64;
  localparam int STRETCH        = MAX_IN_FLIGHT;
  localparam int NUM_REQUESTS   = 2 * WR_PAIRS + READS + MIXED + BURSTS + STRETCH;
  localparam int WORST_WAIT     = 2 * MAX_BURST + SETTLE_CYCLES;
  localparam int SETUP_CYCLES   = 4 + `CACHE_SETUP_BUSY_CYCLES + 8;
  localparam int TIMEOUT_CYCLES = 4 * NUM_REQUESTS * WORST_WAIT + SETUP_CYCLES;

  // Consumer rd_en modes
  localparam int RD_ALWAYS   = 0;
  localparam int RD_BURSTS   = 1;
  localparam int RD_HOLD_LOW = 2;

  logic                  ap_clk;
  logic                  areset_control;
  MemoryPacket           request_in;
  FIFOStateSignalsInput  fifo_response_signals_in;
  FIFOStateSignalsOutput fifo_response_signals_out;
  MemoryPacket           response_out [N];
  logic                  fifo_setup_signal;

  // Reference model state
  logic [`CACHE_LINE_WORDS-1:0][`CACHE_WORD_W-1:0] shadow_lines [`CACHE_NUM_LINES];
  MemoryPacketPayload expected_q [N][$];
  int                 outstanding  = 0;
  int                 packets_seen = 0;
  int                 errors       = 0;
  int                 checks       = 0;
  int                 cycle_count  = 0;
  int                 rd_mode      = RD_ALWAYS;
  int                 burst_left   = 0;
  logic               burst_level  = 1'b1;

  tb_clock_gen inst_clock_gen (
    .ap_clk        (ap_clk),
    .areset_control(areset_control)
  );

  cache_subsystem_top DUT (
    .ap_clk                   (ap_clk),
    .areset_control           (areset_control),
    .request_in               (request_in),
    .fifo_response_signals_in (fifo_response_signals_in),
    .fifo_response_signals_out(fifo_response_signals_out),
    .response_out             (response_out),
    .fifo_setup_signal        (fifo_setup_signal)
  );

  // ------------------------------------------------------------------------
  // Stimulus and model update
  // ------------------------------------------------------------------------
  task automatic issue_request(input MemoryCommand cmd,
                               input logic [`CACHE_ADDRESS_W-1:0] addr,
                               input MemoryBuffer buffer,
                               input logic [`MEMORY_ROUTE_W-1:0] route,
                               input logic [`CACHE_WORD_W-1:0] wdata);
    MemoryPacket        pkt;
    MemoryPacketPayload exp;
    int                 index;
    int                 offset;
    // Keep the FIFO below prog_full
    while (outstanding >= MAX_IN_FLIGHT) begin
      @(posedge ap_clk);
    end
    index  = addr[`CACHE_ADDRESS_W-1:`CACHE_WORD_OFFSET_W];
    offset = addr[`CACHE_WORD_OFFSET_W-1:0];
    if (cmd == CMD_MEM_WRITE) begin
      shadow_lines[index][offset] = wdata;
    end
    // Addressed word, then line words 0 to 2
    exp.meta.address  = addr;
    exp.meta.route    = route;
    exp.meta.buffer   = buffer;
    exp.meta.cmd      = CMD_MEM_RESPONSE;
    exp.data.field[0] = shadow_lines[index][offset];
    for (int k = 1; k < 4; k++) begin
      exp.data.field[k] = shadow_lines[index][k-1];
    end
    // Setup class broadcast, everything else to its route id
    for (int p = 0; p < N; p++) begin
      if (buffer == STRUCT_CU_SETUP || route == `MEMORY_ROUTE_W'(p)) begin
        expected_q[p].push_back(exp);
      end
    end
    outstanding++;
    pkt.valid                = 1'b1;
    pkt.payload.meta.address = addr;
    pkt.payload.meta.route   = route;
    pkt.payload.meta.buffer  = buffer;
    pkt.payload.meta.cmd     = cmd;
    pkt.payload.data.field   = {$urandom, $urandom, $urandom, wdata};
    @(posedge ap_clk);
    request_in <= pkt;
    @(posedge ap_clk);
    request_in.valid <= 1'b0;
  endtask

  task automatic issue_random_request(input int write_pct, input int setup_pct);
    MemoryCommand cmd;
    MemoryBuffer  buffer;
    cmd    = ($urandom_range(99, 0) < write_pct) ? CMD_MEM_WRITE : CMD_MEM_READ;
    buffer = ($urandom_range(99, 0) < setup_pct) ? STRUCT_CU_SETUP
                                                 : MemoryBuffer'($urandom_range(2, 1));
    issue_request(cmd, `CACHE_ADDRESS_W'($urandom), buffer, `MEMORY_ROUTE_W'($urandom),
                  $urandom);
  endtask

  // Same address both times so field 0 shows the new word
  task automatic issue_write_read();
    logic [`CACHE_ADDRESS_W-1:0] addr;
    logic [`MEMORY_ROUTE_W-1:0]  route;
    addr  = `CACHE_ADDRESS_W'($urandom);
    route = `MEMORY_ROUTE_W'($urandom);
    issue_request(CMD_MEM_WRITE, addr, MemoryBuffer'($urandom_range(2, 1)), route, $urandom);
    issue_request(CMD_MEM_READ, addr, MemoryBuffer'($urandom_range(2, 1)), route, $urandom);
  endtask

  task automatic wait_drain();
    while (outstanding > 0) begin
      @(negedge ap_clk);
    end
    // Room for any stray extra packet to show up
    repeat (SETTLE_CYCLES) @(negedge ap_clk);
  endtask

  // Consumer read enable
  always @(posedge ap_clk) begin
    if (rd_mode == RD_ALWAYS) begin
      fifo_response_signals_in.rd_en <= 1'b1;
    end else if (rd_mode == RD_HOLD_LOW) begin
      fifo_response_signals_in.rd_en <= 1'b0;
    end else begin
      if (burst_left == 0) begin
        burst_level = 1'($urandom_range(1, 0));
        burst_left  = $urandom_range(MAX_BURST, 1);
      end
      burst_left--;
      fifo_response_signals_in.rd_en <= burst_level;
    end
  end

  // ------------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------------
  task automatic check_packet(input int port, input MemoryPacketPayload got);
    MemoryPacketPayload exp;
    checks++;
    assert (expected_q[port].size() > 0) else begin
      errors++;
      $display("Packet on requestor %0d at %0t with no request waiting for it", port, $time);
    end
    if (expected_q[port].size() > 0) begin
      exp = expected_q[port].pop_front();
      checks++;
      assert (got == exp) else begin
        errors++;
        $display("FAILED %0t response_out[%0d].payload got %h expected %h",
                 $time, port, got, exp);
      end
    end
  endtask

  // Only valid while nothing is popped
  task automatic check_fifo_flags();
    FIFOStateSignalsOutput exp_flags;
    // No pops and no reset in progress, so valid and both busy flags low
    exp_flags           = '0;
    exp_flags.empty     = (outstanding == 0);
    exp_flags.full      = (outstanding >= `CACHE_FIFO_DEPTH);
    exp_flags.prog_full = (outstanding >= `CACHE_FIFO_PROG_THRESH);
    checks++;
    assert (fifo_response_signals_out === exp_flags) else begin
      errors++;
      $display("FAILED %0t fifo_response_signals_out got %b expected %b",
               $time, fifo_response_signals_out, exp_flags);
    end
  endtask

  task automatic check_reset();
    int wait_cycles;
    wait_cycles = 0;
    @(negedge ap_clk);
    while (areset_control) begin
      @(negedge ap_clk);
    end
    checks += 2;
    assert (fifo_setup_signal === 1'b1) else begin
      errors++;
      $display("FAILED %0t fifo_setup_signal got %b expected 1", $time, fifo_setup_signal);
    end
    assert (fifo_response_signals_out.empty === 1'b1) else begin
      errors++;
      $display("FAILED %0t fifo_response_signals_out.empty got %b expected 1",
               $time, fifo_response_signals_out.empty);
    end
    while (fifo_setup_signal !== 1'b0 && wait_cycles < SETUP_CYCLES) begin
      @(negedge ap_clk);
      wait_cycles++;
    end
    checks += 2;
    assert (fifo_setup_signal === 1'b0) else begin
      errors++;
      $display("fifo_setup_signal still high %0d cycles after reset", wait_cycles);
    end
    repeat (4) @(negedge ap_clk);
    assert (packets_seen == 0) else begin
      errors++;
      $display("response_out went valid before any request was sent");
    end
  endtask

  // Outputs sampled mid-cycle, one FIFO entry per valid cycle
  always @(negedge ap_clk) begin
    logic any_valid;
    any_valid = 1'b0;
    if (!areset_control) begin
      for (int p = 0; p < N; p++) begin
        if (response_out[p].valid) begin
          any_valid = 1'b1;
          check_packet(p, response_out[p].payload);
        end
      end
    end
    if (any_valid) begin
      packets_seen++;
      outstanding--;
    end
  end

  // ------------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------------
  initial begin
    void'($urandom(SEED));
    request_in               = '0;
    fifo_response_signals_in = '0;
    for (int i = 0; i < `CACHE_NUM_LINES; i++) begin
      shadow_lines[i] = '0;
    end
    check_reset();
    for (int k = 0; k < WR_PAIRS; k++) begin
      issue_write_read();
    end
    // Unicast reads only
    for (int k = 0; k < READS; k++) begin
      issue_random_request(0, 0);
    end
    // Setup class mixed in
    for (int k = 0; k < MIXED; k++) begin
      issue_random_request(30, 40);
    end
    wait_drain();
    // Consumer stalls in random bursts
    rd_mode = RD_BURSTS;
    for (int k = 0; k < BURSTS; k++) begin
      issue_random_request(40, 20);
    end
    wait_drain();
    // Long stall, FIFO fills one entry at a time
    rd_mode = RD_HOLD_LOW;
    repeat (4) @(negedge ap_clk);
    check_fifo_flags();
    for (int k = 0; k < STRETCH; k++) begin
      issue_random_request(40, 20);
      repeat (SETTLE_CYCLES) @(negedge ap_clk);
      check_fifo_flags();
    end
    rd_mode = RD_ALWAYS;
    wait_drain();
    for (int p = 0; p < N; p++) begin
      checks++;
      assert (expected_q[p].size() == 0) else begin
        errors++;
        $display("Requestor %0d never got %0d expected packets", p, expected_q[p].size());
      end
    end
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Run limit
  always @(posedge ap_clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d responses outstanding",
               cycle_count, outstanding);
      $display("Summary: %0d checks, %0d errors", checks, errors);
      $display("Errors found");
      $finish;
    end
  end

endmodule : tb_cache_subsystem

//--- sim/tb_clock_gen.sv
/*
  Testbench clock and reset
  Free-running ap_clk at a 100 ns period, areset_control held high
  for the first rising edges after time zero
*/

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int RESET_CYCLES = 4
) (
  output logic ap_clk,
  output logic areset_control
);

  // 50 ns half period
  initial begin
    ap_clk = 1'b0;
    forever begin
      #50 ap_clk = ~ap_clk;
    end
  end

  // Released on a rising edge like any other DUT input
  initial begin
    areset_control = 1'b1;
    repeat (RESET_CYCLES) @(posedge ap_clk);
    areset_control <= 1'b0;
  end

endmodule : tb_clock_gen

//--- source/cache_generator_response.sv
/*
  Cache response generator
  Registers store responses, queues them in the response FIFO with the
  command rewritten to a memory response, and on pop reformats each
  entry into a memory packet. Setup-class packets go to every
  requestor; all others only to the requestor named by the route id
*/

`timescale 1ns/1ps
`include "glay_cache_config.svh"

module cache_generator_response (
  input  logic                            ap_clk,
  input  logic                            areset_control,
  input  pkg_cache::CacheResponse          response_in,
  input  pkg_cache::FIFOStateSignalsInput  fifo_response_signals_in,
  output pkg_cache::FIFOStateSignalsOutput fifo_response_signals_out,
  output pkg_memory::MemoryPacket          response_out [`NUM_MEMORY_REQUESTOR],
  output logic                            fifo_setup_signal
);

  import pkg_memory::*;
  import pkg_cache::*;

  localparam int N = `NUM_MEMORY_REQUESTOR;

  logic                  areset_response;
  logic                  areset_fifo;
  CacheResponse          response_in_reg;
  logic                  fifo_rd_en_reg;
  FIFOStateSignalsInput  fifo_signals_in_int;
  FIFOStateSignalsOutput fifo_signals_out_int;
  CacheResponsePayload   fifo_din;
  CacheResponsePayload   fifo_dout;
  MemoryPacket           fifo_packet;
  MemoryPacket           response_out_next [N];

  // --------------------------------------------------------------------------
  // Local reset copies and input registers
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    areset_response <= areset_control;
    areset_fifo     <= areset_control;
  end

  always_ff @(posedge ap_clk) begin
    if (areset_response) begin
      response_in_reg.valid <= 1'b0;
      fifo_rd_en_reg        <= 1'b0;
      fifo_setup_signal     <= 1'b1;
    end else begin
      response_in_reg.valid <= response_in.valid;
      fifo_rd_en_reg        <= fifo_response_signals_in.rd_en;
      // Setup lasts as long as either side of the FIFO is busy
      fifo_setup_signal <= fifo_signals_out_int.wr_rst_busy | fifo_signals_out_int.rd_rst_busy;
    end
  end

  always_ff @(posedge ap_clk) begin
    response_in_reg.payload   <= response_in.payload;
    fifo_response_signals_out <= fifo_signals_out_int;
  end

  // --------------------------------------------------------------------------
  // Push and pop
  // --------------------------------------------------------------------------
  always_comb begin
    fifo_din          = response_in_reg.payload;
    fifo_din.meta.cmd = CMD_MEM_RESPONSE;
  end

  assign fifo_signals_in_int.wr_en = response_in_reg.valid;
  assign fifo_signals_in_int.rd_en = fifo_rd_en_reg & ~fifo_signals_out_int.empty;

  // Addressed word first, then the head of the line
  assign fifo_packet.valid                 = fifo_signals_out_int.valid;
  assign fifo_packet.payload.meta          = fifo_dout.meta;
  assign fifo_packet.payload.data.field[0] = fifo_dout.iob.rdata;
  assign fifo_packet.payload.data.field[1] = fifo_dout.data.field[0];
  assign fifo_packet.payload.data.field[2] = fifo_dout.data.field[1];
  assign fifo_packet.payload.data.field[3] = fifo_dout.data.field[2];

  cache_response_fifo #(
    .DEPTH(`CACHE_FIFO_DEPTH),
    .WIDTH($bits(CacheResponsePayload))
  ) inst_fifo_cache_response (
    .ap_clk     (ap_clk),
    .srst       (areset_fifo),
    .din        (fifo_din),
    .wr_en      (fifo_signals_in_int.wr_en),
    .rd_en      (fifo_signals_in_int.rd_en),
    .dout       (fifo_dout),
    .full       (fifo_signals_out_int.full),
    .empty      (fifo_signals_out_int.empty),
    .valid      (fifo_signals_out_int.valid),
    .prog_full  (fifo_signals_out_int.prog_full),
    .wr_rst_busy(fifo_signals_out_int.wr_rst_busy),
    .rd_rst_busy(fifo_signals_out_int.rd_rst_busy)
  );

  // --------------------------------------------------------------------------
  // Routing and output registers
  // --------------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < N; i++) begin
      response_out_next[i] = '0;
      if (fifo_packet.valid && (fifo_packet.payload.meta.buffer == STRUCT_CU_SETUP ||
          fifo_packet.payload.meta.route == `MEMORY_ROUTE_W'(i))) begin
        response_out_next[i] = fifo_packet;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < N; i++) begin
      if (areset_response) begin
        response_out[i].valid <= 1'b0;
      end else begin
        response_out[i].valid <= response_out_next[i].valid;
      end
      response_out[i].payload <= response_out_next[i].payload;
    end
  end

  // A push during the FIFO reset-busy span would be dropped
  assert property (@(posedge ap_clk) disable iff (areset_response)
    fifo_signals_in_int.wr_en |-> !fifo_signals_out_int.wr_rst_busy)
  else $error("cache_generator_response: push while FIFO in reset");

endmodule : cache_generator_response

//--- source/cache_line_store.sv
/*
  Cache line store
  Direct-mapped array of lines that always hits. Serves one request
  per cycle with a one cycle latency; a write updates the word first
  and answers with the updated line
*/

`timescale 1ns/1ps
`include "glay_cache_config.svh"

module cache_line_store (
  input  logic                   ap_clk,
  input  logic                   areset_control,
  input  pkg_cache::CacheRequest  request_in,
  output pkg_cache::CacheResponse response_out
);

  import pkg_memory::*;
  import pkg_cache::*;

  localparam int OFFSET_W = `CACHE_WORD_OFFSET_W;
  localparam int INDEX_W  = `CACHE_ADDRESS_W - OFFSET_W;

  CacheData            line_array [`CACHE_NUM_LINES];
  CacheData            line_next;
  logic [INDEX_W-1:0]  line_index;
  logic [OFFSET_W-1:0] word_offset;

  // --------------------------------------------------------------------------
  // Address split and write merge
  // --------------------------------------------------------------------------
  always_comb begin
    line_index  = request_in.payload.meta.address[`CACHE_ADDRESS_W-1:OFFSET_W];
    word_offset = request_in.payload.meta.address[OFFSET_W-1:0];
    line_next   = line_array[line_index];
    // Writes patch the addressed word before the line is returned
    if (request_in.payload.meta.cmd == CMD_MEM_WRITE) begin
      line_next.field[word_offset] = request_in.payload.wdata;
    end
  end

  // --------------------------------------------------------------------------
  // Line array and response valid
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      response_out.valid <= 1'b0;
      for (int i = 0; i < `CACHE_NUM_LINES; i++) begin
        line_array[i] <= '0;
      end
    end else begin
      response_out.valid <= request_in.valid;
      if (request_in.valid && request_in.payload.meta.cmd == CMD_MEM_WRITE) begin
        line_array[line_index] <= line_next;
      end
    end
  end

  // Payload follows the request by one cycle
  always_ff @(posedge ap_clk) begin
    response_out.payload.meta      <= request_in.payload.meta;
    response_out.payload.data      <= line_next;
    response_out.payload.iob.rdata <= line_next.field[word_offset];
  end

endmodule : cache_line_store

//--- source/cache_request_decode.sv
/*
  Cache request decode
  Registers incoming memory packets and turns them into cache
  requests: meta passes as is, write word taken from field 0
*/

`timescale 1ns/1ps

module cache_request_decode (
  input  logic                   ap_clk,
  input  logic                   areset_control,
  input  pkg_memory::MemoryPacket request_in,
  output pkg_cache::CacheRequest  request_out
);

  import pkg_memory::*;

  // --------------------------------------------------------------------------
  // Request valid
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      request_out.valid <= 1'b0;
    end else begin
      request_out.valid <= request_in.valid;
    end
  end

  // --------------------------------------------------------------------------
  // Request payload
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    // Command, address, route and class unchanged
    request_out.payload.meta  <= request_in.payload.meta;
    // Reads ignore this word
    request_out.payload.wdata <= request_in.payload.data.field[0];
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  // Requestors only send reads and writes
  assert property (@(posedge ap_clk) disable iff (areset_control)
    request_in.valid |-> request_in.payload.meta.cmd != CMD_MEM_RESPONSE)
  else $error("cache_request_decode: response command on request input");

endmodule : cache_request_decode

//--- source/cache_response_fifo.sv
/*
  Cache response FIFO
  Synchronous circular buffer with registered read data, a valid flag
  one cycle after rd_en, programmable full, and reset-busy flags held
  for a fixed number of cycles after srst
*/

`timescale 1ns/1ps
`include "glay_cache_config.svh"

module cache_response_fifo #(
  parameter int DEPTH = `CACHE_FIFO_DEPTH,
  parameter int WIDTH = 32
) (
  input  logic             ap_clk,
  input  logic             srst,
  input  logic [WIDTH-1:0] din,
  input  logic             wr_en,
  input  logic             rd_en,
  output logic [WIDTH-1:0] dout,
  output logic             full,
  output logic             empty,
  output logic             valid,
  output logic             prog_full,
  output logic             wr_rst_busy,
  output logic             rd_rst_busy
);

  localparam int PTR_W  = $clog2(DEPTH);
  localparam int BUSY_W = $clog2(`CACHE_SETUP_BUSY_CYCLES + 1);

  logic [WIDTH-1:0]  mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [PTR_W:0]    count;
  logic [BUSY_W-1:0] busy_count;
  logic              rst_busy;
  logic              wr_ok;
  logic              rd_ok;

  // --------------------------------------------------------------------------
  // Flags
  // --------------------------------------------------------------------------
  assign rst_busy    = (busy_count != '0);
  assign wr_rst_busy = rst_busy;
  assign rd_rst_busy = rst_busy;
  assign empty       = (count == '0);
  assign full        = (count == (PTR_W + 1)'(DEPTH));
  assign prog_full   = (count >= (PTR_W + 1)'(`CACHE_FIFO_PROG_THRESH));

  // Requests are dropped while busy or at the limits
  assign wr_ok = wr_en & ~full & ~rst_busy;
  assign rd_ok = rd_en & ~empty & ~rst_busy;

  // --------------------------------------------------------------------------
  // Pointers, count and reset-busy timer
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (srst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      valid      <= 1'b0;
      busy_count <= BUSY_W'(`CACHE_SETUP_BUSY_CYCLES);
    end else begin
      if (rst_busy) begin
        busy_count <= busy_count - 1'b1;
      end
      if (wr_ok) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + (PTR_W + 1)'(wr_ok) - (PTR_W + 1)'(rd_ok);
      valid <= rd_ok;
    end
  end

  // Storage and read data
  always_ff @(posedge ap_clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= din;
    end
    if (rd_ok) begin
      dout <= mem[rd_ptr];
    end
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  // Upstream honors prog_full, so a push never meets a full buffer
  assert property (@(posedge ap_clk) disable iff (srst) wr_en |-> !full)
  else $error("cache_response_fifo: write while full");

  // Reader gates rd_en with not-empty
  assert property (@(posedge ap_clk) disable iff (srst) rd_en |-> !empty)
  else $error("cache_response_fifo: read while empty");

endmodule : cache_response_fifo

//--- source/cache_subsystem_top.sv
/*
  Cache subsystem top
  Request decode, line store and response generator in a chain
*/

`timescale 1ns/1ps
`include "glay_cache_config.svh"

module cache_subsystem_top (
  input  logic                            ap_clk,
  input  logic                            areset_control,
  input  pkg_memory::MemoryPacket          request_in,
  input  pkg_cache::FIFOStateSignalsInput  fifo_response_signals_in,
  output pkg_cache::FIFOStateSignalsOutput fifo_response_signals_out,
  output pkg_memory::MemoryPacket          response_out [`NUM_MEMORY_REQUESTOR],
  output logic                            fifo_setup_signal
);

  import pkg_cache::*;

  CacheRequest  cache_request;
  CacheResponse cache_response;

  // Memory packet to cache request
  cache_request_decode inst_cache_request_decode (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .request_in    (request_in),
    .request_out   (cache_request)
  );

  // Always-hit line array
  cache_line_store inst_cache_line_store (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .request_in    (cache_request),
    .response_out  (cache_response)
  );

  // Buffer, reformat and route back to requestors
  cache_generator_response inst_cache_generator_response (
    .ap_clk                   (ap_clk),
    .areset_control           (areset_control),
    .response_in              (cache_response),
    .fifo_response_signals_in (fifo_response_signals_in),
    .fifo_response_signals_out(fifo_response_signals_out),
    .response_out             (response_out),
    .fifo_setup_signal        (fifo_setup_signal)
  );

endmodule : cache_subsystem_top

//--- source/glay_cache_config.svh
/*
  GLay cache subsystem configuration
  Sizes shared by the packages and the RTL: requestor count, response
  FIFO depth and threshold, line geometry and the FIFO reset-busy span
*/

`ifndef GLAY_CACHE_CONFIG_SVH
`define GLAY_CACHE_CONFIG_SVH

// Requestor side
`define NUM_MEMORY_REQUESTOR 2
`define MEMORY_ROUTE_W 1

// Response FIFO
`define CACHE_FIFO_DEPTH 32
`define CACHE_FIFO_PROG_THRESH 16
`define CACHE_SETUP_BUSY_CYCLES 3

// Line store geometry, word address = {line index, word offset}
`define CACHE_WORD_W 32
`define CACHE_LINE_WORDS 4
`define CACHE_NUM_LINES 16
`define CACHE_ADDRESS_W 6
`define CACHE_WORD_OFFSET_W 2

`endif

//--- source/pkg_cache.sv
/*
  Cache side types
  Requests into and responses out of the line store, plus the
  control and status bundles of the response FIFO
*/

`include "glay_cache_config.svh"

package pkg_cache;

  import pkg_memory::*;

  // ------------------------------------------------------------------------
  // Request and response
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic [`CACHE_WORD_W-1:0] rdata;
  } CacheIOB;

  typedef struct packed {
    logic [`CACHE_LINE_WORDS-1:0][`CACHE_WORD_W-1:0] field;
  } CacheData;

  // Write data comes from wdata
  typedef struct packed {
    MemoryMeta                meta;
    logic [`CACHE_WORD_W-1:0] wdata;
  } CacheRequestPayload;

  typedef struct packed {
    logic               valid;
    CacheRequestPayload payload;
  } CacheRequest;

  typedef struct packed {
    CacheIOB   iob;
    MemoryMeta meta;
    CacheData  data;
  } CacheResponsePayload;

  typedef struct packed {
    logic                valid;
    CacheResponsePayload payload;
  } CacheResponse;

  // ------------------------------------------------------------------------
  // FIFO handshake and flags
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic rd_en;
    logic wr_en;
  } FIFOStateSignalsInput;

  typedef struct packed {
    logic full;
    logic empty;
    logic valid;
    logic prog_full;
    logic wr_rst_busy;
    logic rd_rst_busy;
  } FIFOStateSignalsOutput;

endpackage : pkg_cache

//--- source/pkg_memory.sv
/*
  Memory packet types
  Packets exchanged with the requestors: command and buffer class
  enums, packet meta, four data fields and the valid wrapper
*/

`include "glay_cache_config.svh"

package pkg_memory;

  // ------------------------------------------------------------------------
  // Encodings
  // ------------------------------------------------------------------------
  typedef enum logic [1:0] {
    CMD_MEM_READ,
    CMD_MEM_WRITE,
    CMD_MEM_RESPONSE
  } MemoryCommand;

  // Setup class is broadcast on the way back
  typedef enum logic [1:0] {
    STRUCT_CU_SETUP,
    STRUCT_VERTEX,
    STRUCT_EDGE
  } MemoryBuffer;

  // ------------------------------------------------------------------------
  // Packet
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic [`CACHE_ADDRESS_W-1:0] address;
    logic [`MEMORY_ROUTE_W-1:0]  route;
    MemoryBuffer                 buffer;
    MemoryCommand                cmd;
  } MemoryMeta;

  // Field 0 carries the word of interest
  typedef struct packed {
    logic [3:0][`CACHE_WORD_W-1:0] field;
  } MemoryData;

  typedef struct packed {
    MemoryMeta meta;
    MemoryData data;
  } MemoryPacketPayload;

  typedef struct packed {
    logic               valid;
    MemoryPacketPayload payload;
  } MemoryPacket;

endpackage : pkg_memory
